// ==== all.f ====
+incdir+tests
hw/rxq_pkg.sv
hw/sync_fifo.sv
hw/read_queue.sv
hw/queue_csr.sv
hw/rxq_top.sv
tests/tb_rxq.sv

// ==== tests/rxq_model.svh ====
// Reference model of queue contents, threshold clamping and status flags

  logic [31:0]       model_q[$];
  logic [THLD_W-1:0] model_thld;

  // Linear mode keeps the threshold below DEPTH
  function automatic logic [THLD_W-1:0] clamp_thld(input logic [31:0] wval);
    logic [THLD_W-1:0] raw;
    raw = wval[THLD_W-1:0];
    if (int'(raw) >= int'(DEPTH)) begin
      return THLD_W'(DEPTH - 1);
    end
    return raw;
  endfunction

  // Flags in register order: empty, full, above threshold
  function automatic logic [2:0] model_status();
    logic empty;
    logic full;
    logic above;
    empty = (model_q.size() == 0);
    full  = (model_q.size() == int'(DEPTH));
    above = (model_thld != '0) && (model_q.size() >= int'(model_thld));
    return {empty, full, above};
  endfunction

// ==== tests/tb_rxq.sv ====
// Testbench for the receive queue with seeded random traffic and a queue model
`timescale 1ns/1ns

module tb_rxq;

  import rxq_pkg::*;

  localparam int unsigned DEPTH = 8;
  localparam int unsigned CLK_PERIOD = 8;
  localparam int unsigned N_TXN = 400;

  logic          clk;
  logic          rst_n;
  logic          wvalid;
  logic          wready;
  logic [31:0]   wdata;
  csr_req_t      csr_req;
  csr_rsp_t      csr_rsp;
  queue_status_t status;

  int            errors;
  int            seed;
  logic [31:0]   rd;
  logic [31:0]   word;

  `include "rxq_model.svh"

  rxq_top #(
    .DEPTH      (DEPTH),
    .THLD_IS_POW(0)
  ) dut0 (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .wvalid_i (wvalid),
    .wready_o (wready),
    .wdata_i  (wdata),
    .csr_req_i(csr_req),
    .csr_rsp_o(csr_rsp),
    .status_o (status)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Budget of 200 cycles per planned transaction
  initial begin
    #(N_TXN * 200 * CLK_PERIOD);
    $display("Timeout after %0d cycles, the DUT stopped responding", N_TXN * 200);
    $display("Finished with errors");
    $finish;
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    errors++;
    $display("FAIL %s expected %h actual %h", name, exp, act);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Offer one word on the write stream until it is taken
  task automatic push_word(input logic [31:0] data);
    logic taken;
    taken  = 1'b0;
    wvalid = 1'b1;
    wdata  = data;
    while (!taken) begin
      @(negedge clk);
      taken = wready;
      next_cycle();
    end
    wvalid = 1'b0;
    model_q.push_back(data);
  endtask

  // Full four-phase access, then a few idle cycles
  task automatic csr_access(input logic we, input csr_addr_e addr,
                            input logic [31:0] wval, output logic [31:0] rval);
    csr_req.req   = 1'b1;
    csr_req.we    = we;
    csr_req.addr  = addr;
    csr_req.wdata = wval;
    do @(negedge clk); while (!csr_rsp.ack);
    rval = csr_rsp.rdata;
    next_cycle();
    csr_req.req = 1'b0;
    do @(negedge clk); while (csr_rsp.ack);
    repeat (4) next_cycle();
  endtask

  task automatic read_data(input string name);
    logic [31:0] exp;
    exp = model_q.pop_front();
    csr_access(1'b0, DATA, '0, rd);
    if (rd !== exp) report_mismatch(name, exp, rd);
  endtask

  task automatic check_status(input string name);
    logic [31:0] exp;
    exp = {29'd0, model_status()};
    csr_access(1'b0, QUEUE_STATUS, '0, rd);
    if (rd !== exp) report_mismatch(name, exp, rd);
    if (status !== exp[2:0]) report_mismatch({name, " port"}, exp, 32'(status));
  endtask

  initial begin
    int burst;
    int n;
    logic [31:0] first;
    seed       = 32'h21fdd83e;
    errors     = 0;
    model_thld = '0;
    rst_n      = 1'b0;
    wvalid     = 1'b0;
    wdata      = '0;
    csr_req    = '0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    next_cycle();
    check_status("status after reset");

    // Random bursts, read back in order
    repeat (12) begin
      burst = 1 + int'($unsigned($random(seed)) % (DEPTH - model_q.size()));
      repeat (burst) push_word($random(seed));
      n = 1 + int'($unsigned($random(seed)) % model_q.size());
      repeat (n) read_data("order");
    end
    while (model_q.size() > 0) read_data("order drain");

    // Fill up, then one extra word held by back-pressure
    repeat (DEPTH) push_word($random(seed));
    check_status("full status");
    wvalid = 1'b1;
    wdata  = $random(seed);
    repeat (3) begin
      @(negedge clk);
      if (wready !== 1'b0) report_mismatch("full wready", 32'd0, 32'(wready));
      next_cycle();
    end
    wvalid = 1'b0;
    read_data("full first word");
    @(negedge clk);
    if (wready !== 1'b1) report_mismatch("wready after read", 32'd1, 32'(wready));
    next_cycle();
    while (model_q.size() > 0) read_data("full drain");
    check_status("empty after full");

    // Threshold writes mixed with pushes and reads
    repeat (16) begin
      word = $random(seed);
      csr_access(1'b1, QUEUE_THLD_CTRL, word, rd);
      model_thld = clamp_thld(word);
      csr_access(1'b0, QUEUE_THLD_CTRL, '0, rd);
      if (rd !== 32'(model_thld)) report_mismatch("thld readback", 32'(model_thld), rd);
      check_status("thld after write");
      if (model_q.size() == 0 || (model_q.size() < int'(DEPTH) && word[31])) begin
        push_word($random(seed));
      end else begin
        read_data("thld read");
      end
      check_status("thld after access");
    end
    while (model_q.size() > 0) read_data("thld drain");

    // Soft reset with data queued
    repeat (5) push_word($random(seed));
    csr_access(1'b1, QUEUE_RST_CTRL, 32'd1, rd);
    model_q.delete();
    check_status("soft reset status");
    csr_access(1'b0, QUEUE_RST_CTRL, '0, rd);
    if (rd !== 32'd0) report_mismatch("soft reset readback", 32'd0, rd);
    push_word($random(seed));
    push_word($random(seed));
    check_status("after soft reset");
    read_data("after soft reset");
    read_data("after soft reset");

    // DATA read on an empty queue waits for the next word
    word = $random(seed);
    fork
      csr_access(1'b0, DATA, '0, rd);
      begin
        repeat (10) begin
          @(negedge clk);
          if (csr_rsp.ack !== 1'b0) begin
            report_mismatch("empty read early ack", 32'd0, 32'(csr_rsp.ack));
          end
          next_cycle();
        end
        push_word(word);
      end
    join
    first = model_q.pop_front();
    if (rd !== first) report_mismatch("read while empty", first, rd);
    check_status("final status");

    $display("Error count: %0d", errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== hw/rxq_top.sv ====
// Top level of the receive path, register block beside the read queue
`timescale 1ns/1ns

module rxq_top #(
  parameter int unsigned DEPTH = 8,
  parameter int unsigned THLD_IS_POW = 0
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       wvalid_i,
  output logic                       wready_o,
  input  logic [rxq_pkg::DATA_W-1:0] wdata_i,
  input  rxq_pkg::csr_req_t          csr_req_i,
  output rxq_pkg::csr_rsp_t          csr_rsp_o,
  output rxq_pkg::queue_status_t     status_o
);

  import rxq_pkg::*;

  logic              pop_req;
  logic              pop_ack;
  logic [DATA_W-1:0] pop_data;
  logic [THLD_W-1:0] thld;
  logic [THLD_W-1:0] thld_clamped;
  logic              soft_rst;
  logic              soft_rst_done;

  queue_csr u_csr (
    .clk_i,
    .rst_ni,
    .csr_req_i,
    .csr_rsp_o,
    .thld_o         (thld),
    .thld_clamped_i (thld_clamped),
    .soft_rst_o     (soft_rst),
    .soft_rst_done_i(soft_rst_done),
    .status_i       (status_o),
    .pop_req_o      (pop_req),
    .pop_ack_i      (pop_ack),
    .pop_data_i     (pop_data)
  );

  read_queue #(
    .DEPTH      (DEPTH),
    .THLD_IS_POW(THLD_IS_POW)
  ) u_queue (
    .clk_i,
    .rst_ni,
    .wvalid_i,
    .wready_o,
    .wdata_i,
    .pop_req_i      (pop_req),
    .pop_ack_o      (pop_ack),
    .pop_data_o     (pop_data),
    .thld_i         (thld),
    .thld_clamped_o (thld_clamped),
    .soft_rst_i     (soft_rst),
    .soft_rst_done_o(soft_rst_done),
    .status_o
  );

endmodule

// ==== hw/queue_csr.sv ====
// Register block for the read queue with host handshake and pop bridge
`timescale 1ns/1ns

module queue_csr (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  rxq_pkg::csr_req_t          csr_req_i,
  output rxq_pkg::csr_rsp_t          csr_rsp_o,
  output logic [rxq_pkg::THLD_W-1:0] thld_o,
  input  logic [rxq_pkg::THLD_W-1:0] thld_clamped_i,
  output logic                       soft_rst_o,
  input  logic                       soft_rst_done_i,
  input  rxq_pkg::queue_status_t     status_i,
  output logic                       pop_req_o,
  input  logic                       pop_ack_i,
  input  logic [rxq_pkg::DATA_W-1:0] pop_data_i
);

  import rxq_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACCESS,
    ST_POP_WAIT,
    ST_RESP
  } state_e;

  state_e            state_q;
  logic              we_q;
  csr_addr_e         addr_q;
  csr_word_u         wword_q;
  csr_word_u         rword;
  logic              ack_q;
  logic [DATA_W-1:0] rdata_q;
  logic [THLD_W-1:0] thld_q;
  logic              soft_rst_q;
  logic              pop_req_q;
  logic              data_read;

  assign data_read = ~we_q && (addr_q == DATA);

  // Readback word for the plain registers
  always_comb begin
    rword = '0;
    case (addr_q)
      QUEUE_THLD_CTRL: rword.thld.thld = thld_clamped_i;
      QUEUE_RST_CTRL:  rword.rst.soft_rst = soft_rst_q;
      QUEUE_STATUS:    rword = DATA_W'(status_i);
      default:         rword = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ST_IDLE;
      ack_q      <= 1'b0;
      pop_req_q  <= 1'b0;
      thld_q     <= '0;
      soft_rst_q <= 1'b0;
    end else begin
      pop_req_q <= 1'b0;
      // Self-clearing once the queue reports the flush done
      if (soft_rst_done_i) begin
        soft_rst_q <= 1'b0;
      end
      case (state_q)
        ST_IDLE: begin
          if (csr_req_i.req) begin
            state_q <= ST_ACCESS;
          end
        end
        ST_ACCESS: begin
          if (data_read) begin
            pop_req_q <= 1'b1;
            state_q   <= ST_POP_WAIT;
          end else begin
            ack_q   <= 1'b1;
            state_q <= ST_RESP;
            // Each address decodes the word through its own view
            if (we_q && addr_q == QUEUE_THLD_CTRL) begin
              thld_q <= wword_q.thld.thld;
            end
            if (we_q && addr_q == QUEUE_RST_CTRL && wword_q.rst.soft_rst) begin
              soft_rst_q <= 1'b1;
            end
          end
        end
        ST_POP_WAIT: begin
          // Empty queue keeps us here until a word arrives
          if (pop_ack_i) begin
            ack_q   <= 1'b1;
            state_q <= ST_RESP;
          end
        end
        ST_RESP: begin
          if (!csr_req_i.req) begin
            ack_q   <= 1'b0;
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Request fields and read data
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && csr_req_i.req) begin
      we_q    <= csr_req_i.we;
      addr_q  <= csr_req_i.addr;
      wword_q <= csr_req_i.wdata;
    end
    if (state_q == ST_ACCESS) begin
      rdata_q <= rword;
    end else if (state_q == ST_POP_WAIT && pop_ack_i) begin
      rdata_q <= pop_data_i;
    end
  end

  assign csr_rsp_o.ack   = ack_q;
  assign csr_rsp_o.rdata = rdata_q;
  assign thld_o          = thld_q;
  assign soft_rst_o      = soft_rst_q;
  assign pop_req_o       = pop_req_q;

endmodule

// ==== hw/read_queue.sv ====
// Read queue with threshold clamping, soft-reset flush and one-cycle pop port
`timescale 1ns/1ns

module read_queue #(
  parameter int unsigned DEPTH = 8,
  parameter int unsigned THLD_IS_POW = 0,
  localparam int unsigned DEPTH_W = $clog2(DEPTH + 1)
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       wvalid_i,
  output logic                       wready_o,
  input  logic [rxq_pkg::DATA_W-1:0] wdata_i,
  input  logic                       pop_req_i,
  output logic                       pop_ack_o,
  output logic [rxq_pkg::DATA_W-1:0] pop_data_o,
  input  logic [rxq_pkg::THLD_W-1:0] thld_i,
  output logic [rxq_pkg::THLD_W-1:0] thld_clamped_o,
  input  logic                       soft_rst_i,
  output logic                       soft_rst_done_o,
  output rxq_pkg::queue_status_t     status_o
);

  import rxq_pkg::*;

  // Largest exponent in power mode
  localparam int POW_MAX = $clog2(DEPTH) - 2;

  logic [THLD_W-1:0]  thld_q;
  logic [THLD_W-1:0]  thld_next;
  logic [DEPTH_W-1:0] thld_level;
  logic               fifo_wvalid;
  logic               fifo_wready;
  logic               fifo_rvalid;
  logic               fifo_rready;
  logic [DATA_W-1:0]  fifo_rdata;
  logic [DEPTH_W-1:0] fifo_depth;
  logic               fifo_full;
  logic               fifo_pop;

  // Writer holds its word while a flush is under way
  assign fifo_wvalid = wvalid_i & ~soft_rst_i;
  assign wready_o    = fifo_wready & ~soft_rst_i;

  assign fifo_pop = fifo_rready & fifo_rvalid;

  always_comb begin
    if (THLD_IS_POW == 0) begin
      // Linear threshold must stay below DEPTH
      thld_next = (32'(thld_q) >= DEPTH) ? THLD_W'(DEPTH - 1) : thld_q;
    end else begin
      // Level is 2^(t+1), also below DEPTH
      thld_next = ((32'd1 << (32'(thld_q) + 1)) >= DEPTH) ? THLD_W'(POW_MAX) : thld_q;
    end
  end

  always_comb begin
    if (THLD_IS_POW == 0) begin
      thld_level = DEPTH_W'(thld_clamped_o);
    end else begin
      thld_level = DEPTH_W'(1) << (32'(thld_clamped_o) + 1);
    end
  end

  assign status_o.empty      = (fifo_depth == '0);
  assign status_o.full       = fifo_full;
  assign status_o.above_thld = (thld_clamped_o != '0) && (fifo_depth >= thld_level);

  // Input stage, then clamp
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      thld_q         <= '0;
      thld_clamped_o <= '0;
    end else begin
      thld_q         <= thld_i;
      thld_clamped_o <= thld_next;
    end
  end

  // The clear lands on the same edge, so the queue is empty with the pulse
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      soft_rst_done_o <= 1'b0;
    end else begin
      soft_rst_done_o <= soft_rst_i & ~soft_rst_done_o;
    end
  end

  // Pop port, a pending request waits for data
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fifo_rready <= 1'b0;
      pop_ack_o   <= 1'b0;
    end else if (soft_rst_i) begin
      fifo_rready <= 1'b0;
      pop_ack_o   <= 1'b0;
    end else begin
      pop_ack_o <= fifo_pop;
      if (fifo_pop) begin
        fifo_rready <= 1'b0;
      end else if (pop_req_i) begin
        fifo_rready <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fifo_pop) begin
      pop_data_o <= fifo_rdata;
    end
  end

  sync_fifo #(
    .DEPTH(DEPTH)
  ) u_fifo (
    .clk_i,
    .rst_ni,
    .clr_i   (soft_rst_i),
    .wvalid_i(fifo_wvalid),
    .wready_o(fifo_wready),
    .wdata_i,
    .rvalid_o(fifo_rvalid),
    .rready_i(fifo_rready),
    .rdata_o (fifo_rdata),
    .depth_o (fifo_depth),
    .full_o  (fifo_full)
  );

  // An acknowledged pop took a word that was really stored
  a_no_ack_when_empty: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pop_ack_o |-> !$past(status_o.empty)
  );

  a_done_in_soft_rst: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    soft_rst_done_o |-> soft_rst_i
  );

endmodule

// ==== hw/sync_fifo.sv ====
// Synchronous FIFO with clear, fill count and first-word read data
`timescale 1ns/1ns

module sync_fifo #(
  parameter int unsigned DEPTH = 8,
  localparam int unsigned DEPTH_W = $clog2(DEPTH + 1)
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clr_i,
  input  logic                      wvalid_i,
  output logic                      wready_o,
  input  logic [rxq_pkg::DATA_W-1:0] wdata_i,
  output logic                      rvalid_o,
  input  logic                      rready_i,
  output logic [rxq_pkg::DATA_W-1:0] rdata_o,
  output logic [DEPTH_W-1:0]        depth_o,
  output logic                      full_o
);

  import rxq_pkg::*;

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [DATA_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [DEPTH_W-1:0] count_q;
  logic              push;
  logic              pop;

  assign full_o   = (count_q == DEPTH_W'(DEPTH));
  assign wready_o = ~full_o;
  assign rvalid_o = (count_q != '0);
  assign depth_o  = count_q;

  assign push = wvalid_i & wready_o;
  assign pop  = rvalid_o & rready_i;

  // Head entry is always presented
  assign rdata_o = mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clr_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keep the count
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Fill count stays within the memory, also across clears and wrap
  a_depth_bound: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    depth_o <= DEPTH_W'(DEPTH)
  );

endmodule

// ==== hw/rxq_pkg.sv ====
// Register map, host bus structs, control-word views and queue status type
package rxq_pkg;

  // Queue entry and register word width
  parameter int unsigned DATA_W = 32;

  // Threshold field width
  parameter int unsigned THLD_W = 3;

  typedef enum logic [1:0] {
    DATA            = 2'd0,
    QUEUE_THLD_CTRL = 2'd1,
    QUEUE_RST_CTRL  = 2'd2,
    QUEUE_STATUS    = 2'd3
  } csr_addr_e;

  // Host request, held stable while req is high
  typedef struct packed {
    logic              req;
    logic              we;
    csr_addr_e         addr;
    logic [DATA_W-1:0] wdata;
  } csr_req_t;

  typedef struct packed {
    logic              ack;
    logic [DATA_W-1:0] rdata;
  } csr_rsp_t;

  typedef struct packed {
    logic [DATA_W-THLD_W-1:0] rsvd;
    logic [THLD_W-1:0]        thld;
  } thld_view_t;

  typedef struct packed {
    logic [DATA_W-2:0] rsvd;
    logic              soft_rst;
  } rst_view_t;

  // One control word, two decodings
  typedef union packed {
    thld_view_t thld;
    rst_view_t  rst;
  } csr_word_u;

  typedef struct packed {
    logic empty;
    logic full;
    logic above_thld;
  } queue_status_t;

endpackage
